// ==== source/av_pll_reconfig_pkg.sv ====
//====================================================================
// Shared widths, block indices and CSR offsets for one CMU TX PLL
// Every access is a full 16-bit word, so byte enables are not modelled
//====================================================================
package av_pll_reconfig_pkg;

  // Bus geometry
  localparam int AVMM_ADDR_W   = 12;
  localparam int AVMM_DATA_W   = 16;
  localparam int CSR_OFFSET_W  = 4;
  localparam int DPRIO_BLOCK_W = 7;
  localparam int DPRIO_REG_W   = 4;
  // Bits between the select bit and the CSR offset
  localparam int CSR_RSVD_W    = AVMM_ADDR_W - 1 - CSR_OFFSET_W;

  // Hard block indices on the DPRIO bus
  localparam logic [DPRIO_BLOCK_W-1:0] BLOCK_CMU_PLL    = 7'd5;
  localparam logic [DPRIO_BLOCK_W-1:0] BLOCK_REFCLK_MUX = 7'd6;

  // Refclk mux has iqclk0 to iqclk10
  localparam int REFCLK_COUNT = 11;
  localparam int REFCLK_SEL_W = $clog2(REFCLK_COUNT);

  // Soft CSR map
  localparam logic [AVMM_DATA_W-1:0]  PLL_TYPE_CMU = 16'd1;
  localparam logic [CSR_OFFSET_W-1:0] CSR_PLL_TYPE = 4'd0;
  localparam logic [CSR_OFFSET_W-1:0] CSR_STATUS   = 4'd1;

  // Register offsets inside the hard blocks
  localparam logic [DPRIO_REG_W-1:0] REG_FB_HCLK    = 4'd0;
  localparam logic [DPRIO_REG_W-1:0] REG_REFCLK_SEL = 4'd0;

  // Settings after reset: iqclk0, internal feedback, hclk off
  localparam logic [REFCLK_SEL_W-1:0] REFCLK_SEL_RESET = '0;
  localparam logic [1:0]              FB_HCLK_RESET    = 2'b00;

  // One address word, two decodes; select bit on top of both
  typedef union packed {
    struct packed {
      logic                    sel;
      logic [CSR_RSVD_W-1:0]   rsvd;
      logic [CSR_OFFSET_W-1:0] offset;
    } csr;
    struct packed {
      logic                     sel;
      logic [DPRIO_BLOCK_W-1:0] block;
      logic [DPRIO_REG_W-1:0]   reg_offset;
    } dprio;
  } avmm_addr_u;

endpackage

// ==== source/avmm_port_if.sv ====
//====================================================================
// Register port between the bus split and one register agent
// Single-cycle strobes, no wait states; readdata is combinational
//====================================================================
interface avmm_port_if;
  import av_pll_reconfig_pkg::*;

  // Host side strobes and payload
  logic                   write;
  logic                   read;
  avmm_addr_u             offset;
  logic [AVMM_DATA_W-1:0] writedata;
  // Agent answer for the current offset
  logic [AVMM_DATA_W-1:0] readdata;

  modport host (
    output write,
    output read,
    output offset,
    output writedata,
    input  readdata
  );

  modport agent (
    input  write,
    input  read,
    input  offset,
    input  writedata,
    output readdata
  );

endinterface

// ==== source/avmm_csr_dprio_split.sv ====
//====================================================================
// Splits the host bus into soft CSR (bit 11 set) and DPRIO space
// Fixed read latency of one cycle; results of back-to-back reads
// come out in order, one per cycle
//====================================================================
module avmm_csr_dprio_split (
  input  logic                                        pld_avmm_clk,
  input  logic                                        pld_avmm_reset,
  input  logic [av_pll_reconfig_pkg::AVMM_ADDR_W-1:0] address,
  input  logic [av_pll_reconfig_pkg::AVMM_DATA_W-1:0] writedata,
  input  logic                                        write,
  input  logic                                        read,
  output logic [av_pll_reconfig_pkg::AVMM_DATA_W-1:0] readdata,
  output logic                                        readdata_valid,
  avmm_port_if.host                                   csr_port,
  avmm_port_if.host                                   dprio_port
);
  import av_pll_reconfig_pkg::*;

  avmm_addr_u             addr_u;
  logic                   csr_sel;
  // Select bit of the last read
  logic                   csr_sel_r;
  logic [AVMM_DATA_W-1:0] csr_rdata_q;
  logic [AVMM_DATA_W-1:0] dprio_rdata_q;

  assign addr_u = address;
  // Both views share the top bit, CSR view used here
  assign csr_sel = addr_u.csr.sel;

  // Strobes only reach the selected side
  assign csr_port.write   = write & csr_sel;
  assign csr_port.read    = read & csr_sel;
  assign dprio_port.write = write & ~csr_sel;
  assign dprio_port.read  = read & ~csr_sel;

  // Address and data fan out to both sides
  assign csr_port.offset     = addr_u;
  assign csr_port.writedata  = writedata;
  assign dprio_port.offset   = addr_u;
  assign dprio_port.writedata = writedata;

  // Capture the answer at the edge the read strobe is sampled
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      csr_sel_r      <= 1'b0;
      readdata_valid <= 1'b0;
      csr_rdata_q    <= '0;
      dprio_rdata_q  <= '0;
    end else begin
      readdata_valid <= read;
      if (read) begin
        csr_sel_r <= csr_sel;
      end
      if (csr_port.read) begin
        csr_rdata_q <= csr_port.readdata;
      end
      if (dprio_port.read) begin
        dprio_rdata_q <= dprio_port.readdata;
      end
    end
  end

  // Return mux follows the side of the last read
  assign readdata = csr_sel_r ? csr_rdata_q : dprio_rdata_q;

endmodule

// ==== source/pll_soft_csr.sv ====
//====================================================================
// Soft status registers: PLL type and lock status
// Lock passes two flops, so status lags pll_locked by two cycles
//====================================================================
module pll_soft_csr (
  input  logic        pld_avmm_clk,
  input  logic        pld_avmm_reset,
  // From the PLL, not related to the bus clock
  input  logic        pll_locked,
  avmm_port_if.agent  csr_port
);
  import av_pll_reconfig_pkg::*;

  logic lock_meta;
  logic lock_sync;
  // Sticky, set on lock loss
  logic lock_lost;
  logic lock_fall;
  logic status_wr;

  // Two-flop synchronizer on the lock input
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_meta <= pll_locked;
      lock_sync <= lock_meta;
    end
  end

  // Falls at the same edge lock_sync drops
  assign lock_fall = lock_sync & ~lock_meta;
  assign status_wr = csr_port.write && (csr_port.offset.csr.offset == CSR_STATUS);

  // Write 1 to bit 1 clears; a new loss wins over the clear
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      lock_lost <= 1'b0;
    end else if (lock_fall) begin
      lock_lost <= 1'b1;
    end else if (status_wr && csr_port.writedata[1]) begin
      lock_lost <= 1'b0;
    end
  end

  // Read mux by CSR offset
  always_comb begin
    csr_port.readdata = '0;
    case (csr_port.offset.csr.offset)
      CSR_PLL_TYPE: csr_port.readdata = PLL_TYPE_CMU;
      CSR_STATUS: begin
        csr_port.readdata[0] = lock_sync;
        csr_port.readdata[1] = lock_lost;
      end
      // unmapped offsets read zero
      default: csr_port.readdata = '0;
    endcase
  end

endmodule

// ==== source/dprio_channel.sv ====
//====================================================================
// DPRIO channel with the CMU PLL (block 5) and refclk mux (block 6)
// Other blocks and registers read zero; illegal refclk picks are dropped
//====================================================================
module dprio_channel (
  input  logic                                         pld_avmm_clk,
  input  logic                                         pld_avmm_reset,
  avmm_port_if.agent                                   dprio_port,
  output logic [av_pll_reconfig_pkg::REFCLK_SEL_W-1:0] refclk_sel,
  output logic                                         fb_external,
  output logic                                         hclk_enable
);
  import av_pll_reconfig_pkg::*;

  // Block selects from the DPRIO view of the address
  logic                   cmu_sel;
  logic                   mux_sel;
  logic                   fb_hclk_hit;
  logic                   refclk_hit;
  logic                   refclk_legal;
  // Per-block readback before the block mux
  logic [AVMM_DATA_W-1:0] cmu_rdata;
  logic [AVMM_DATA_W-1:0] mux_rdata;

  assign cmu_sel = (dprio_port.offset.dprio.block == BLOCK_CMU_PLL);
  assign mux_sel = (dprio_port.offset.dprio.block == BLOCK_REFCLK_MUX);

  assign fb_hclk_hit = cmu_sel && (dprio_port.offset.dprio.reg_offset == REG_FB_HCLK);
  assign refclk_hit  = mux_sel && (dprio_port.offset.dprio.reg_offset == REG_REFCLK_SEL);

  // Only iqclk0..iqclk10 exist
  assign refclk_legal = (dprio_port.writedata < AVMM_DATA_W'(REFCLK_COUNT));

  // CMU PLL feedback and hclk controls
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      {hclk_enable, fb_external} <= FB_HCLK_RESET;
    end else if (dprio_port.write && fb_hclk_hit) begin
      fb_external <= dprio_port.writedata[0];
      hclk_enable <= dprio_port.writedata[1];
    end
  end

  // Refclk mux select
  always_ff @(posedge pld_avmm_clk or posedge pld_avmm_reset) begin
    if (pld_avmm_reset) begin
      refclk_sel <= REFCLK_SEL_RESET;
    end else if (dprio_port.write && refclk_hit && refclk_legal) begin
      refclk_sel <= dprio_port.writedata[REFCLK_SEL_W-1:0];
    end
  end

  // CMU block readback
  always_comb begin
    cmu_rdata = '0;
    if (dprio_port.offset.dprio.reg_offset == REG_FB_HCLK) begin
      cmu_rdata[0] = fb_external;
      cmu_rdata[1] = hclk_enable;
    end
  end

  // Mux block readback
  always_comb begin
    mux_rdata = '0;
    if (dprio_port.offset.dprio.reg_offset == REG_REFCLK_SEL) begin
      mux_rdata[REFCLK_SEL_W-1:0] = refclk_sel;
    end
  end

  // Block select picks the source, nothing selected reads zero
  always_comb begin
    if (cmu_sel) begin
      dprio_port.readdata = cmu_rdata;
    end else if (mux_sel) begin
      dprio_port.readdata = mux_rdata;
    end else begin
      dprio_port.readdata = '0;
    end
  end

endmodule

// ==== source/av_pll_reconfig.sv ====
//====================================================================
// Reconfiguration access path of a single CMU TX PLL
// Read data returns one cycle after the read strobe; no back-pressure
// Host must not raise write and read in the same cycle
//====================================================================
module av_pll_reconfig (
  input  logic                                        pld_avmm_clk,
  input  logic                                        pld_avmm_reset,
  // Host bus
  input  logic [av_pll_reconfig_pkg::AVMM_ADDR_W-1:0] address,
  input  logic [av_pll_reconfig_pkg::AVMM_DATA_W-1:0] writedata,
  input  logic                                        write,
  input  logic                                        read,
  output logic [av_pll_reconfig_pkg::AVMM_DATA_W-1:0] readdata,
  output logic                                        readdata_valid,
  // PLL status, async to the bus clock
  input  logic                                        pll_locked,
  // PLL settings
  output logic [av_pll_reconfig_pkg::REFCLK_SEL_W-1:0] refclk_sel,
  output logic                                         fb_external,
  output logic                                         hclk_enable
);

  // Soft CSR side of the split
  avmm_port_if csr_if ();
  // Hard DPRIO side of the split
  avmm_port_if dprio_if ();

  // Address bit 11 steers each access
  avmm_csr_dprio_split avmm_csr_dprio_split_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .address        (address),
    .writedata      (writedata),
    .write          (write),
    .read           (read),
    .readdata       (readdata),
    .readdata_valid (readdata_valid),
    .csr_port       (csr_if.host),
    .dprio_port     (dprio_if.host)
  );

  // PLL type and lock status
  pll_soft_csr pll_soft_csr_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .pll_locked     (pll_locked),
    .csr_port       (csr_if.agent)
  );

  // CMU PLL and refclk mux settings
  dprio_channel dprio_channel_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .dprio_port     (dprio_if.agent),
    .refclk_sel     (refclk_sel),
    .fb_external    (fb_external),
    .hclk_enable    (hclk_enable)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
//====================================================================
// Free-running testbench clock, starts low, first rising edge at PERIOD/2
//====================================================================
module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    // Half period per phase
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// ==== test/tb_av_pll_reconfig.sv ====
//====================================================================
// Replays the operations of the stimulus file on the PLL reconfig bus
// Stops at the first error; run from the project root for the file path
//====================================================================
module tb_av_pll_reconfig;
  import av_pll_reconfig_pkg::*;

  localparam string STIM_FILE = "test/av_pll_reconfig_stim.txt";
  localparam int    MAX_LINES = 64;
  // Four words per stimulus line: op, address, data, expected
  localparam int    STIM_WORDS = 4 * MAX_LINES;

  localparam logic [15:0] OP_IDLE    = 16'h0;
  localparam logic [15:0] OP_WRITE   = 16'h1;
  localparam logic [15:0] OP_READ    = 16'h2;
  localparam logic [15:0] OP_LOCK    = 16'h3;
  localparam logic [15:0] OP_OUTPUTS = 16'h4;
  localparam logic [15:0] OP_END     = 16'hf;

  logic                    pld_avmm_clk;
  logic                    pld_avmm_reset;
  logic [AVMM_ADDR_W-1:0]  address;
  logic [AVMM_DATA_W-1:0]  writedata;
  logic                    write;
  logic                    read;
  logic [AVMM_DATA_W-1:0]  readdata;
  logic                    readdata_valid;
  logic                    pll_locked;
  logic [REFCLK_SEL_W-1:0] refclk_sel;
  logic                    fb_external;
  logic                    hclk_enable;

  logic [15:0] stim_mem [0:STIM_WORDS-1];
  // Expected read results, oldest first
  logic [15:0] expected_q [$];
  logic [15:0] expect_word;
  logic [15:0] op;
  logic [15:0] got_outputs;
  int          line_count;
  int          line_idx;
  int          base;
  int          cycle_count = 0;
  // Zero until the stimulus is loaded
  int          cycle_limit = 0;

  tb_clock_gen #(
    .PERIOD (8)
  ) tb_clock_gen_i (
    .clk (pld_avmm_clk)
  );

  av_pll_reconfig av_pll_reconfig_i (
    .pld_avmm_clk   (pld_avmm_clk),
    .pld_avmm_reset (pld_avmm_reset),
    .address        (address),
    .writedata      (writedata),
    .write          (write),
    .read           (read),
    .readdata       (readdata),
    .readdata_valid (readdata_valid),
    .pll_locked     (pll_locked),
    .refclk_sel     (refclk_sel),
    .fb_external    (fb_external),
    .hclk_enable    (hclk_enable)
  );

  // Error line, fail message, stop
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Cycle budget guard
  always @(posedge pld_avmm_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      report_failure($sformatf("Timeout after %0d cycles, the run did not finish", cycle_count));
    end
  end

  // Read results checked mid-cycle, where they are stable
  always @(negedge pld_avmm_clk) begin
    if (!pld_avmm_reset && readdata_valid) begin
      assert (expected_q.size() != 0)
        else report_failure("readdata_valid was high with no read outstanding");
      expect_word = expected_q.pop_front();
      assert (readdata == expect_word)
        else report_failure($sformatf("Mismatch readdata: got 0x%04h expected 0x%04h",
                                      readdata, expect_word));
    end
  end

  initial begin
    pld_avmm_reset = 1'b1;
    address        = '0;
    writedata      = '0;
    write          = 1'b0;
    read           = 1'b0;
    pll_locked     = 1'b0;
    $readmemh(STIM_FILE, stim_mem);
    // Count lines up to the end marker
    line_count = 0;
    while (line_count < MAX_LINES && stim_mem[4 * line_count] != OP_END) begin
      line_count++;
    end
    cycle_limit = 20 * line_count + 100;

    repeat (8) @(posedge pld_avmm_clk);
    pld_avmm_reset <= 1'b0;
    @(negedge pld_avmm_clk);
    assert (readdata_valid == 1'b0)
      else report_failure($sformatf("Mismatch readdata_valid: got 0x%h expected 0x0",
                                    readdata_valid));
    assert (readdata == '0)
      else report_failure($sformatf("Mismatch readdata: got 0x%04h expected 0x0000", readdata));

    for (line_idx = 0; line_idx < line_count; line_idx++) begin
      base = 4 * line_idx;
      op   = stim_mem[base];
      @(posedge pld_avmm_clk);
      // Strobes last one cycle
      write <= 1'b0;
      read  <= 1'b0;
      case (op)
        OP_IDLE: begin
          repeat (stim_mem[base + 2]) @(posedge pld_avmm_clk);
        end
        OP_WRITE: begin
          address   <= stim_mem[base + 1][AVMM_ADDR_W-1:0];
          writedata <= stim_mem[base + 2];
          write     <= 1'b1;
        end
        OP_READ: begin
          address <= stim_mem[base + 1][AVMM_ADDR_W-1:0];
          read    <= 1'b1;
          expected_q.push_back(stim_mem[base + 3]);
        end
        OP_LOCK: begin
          pll_locked <= stim_mem[base + 2][0];
        end
        OP_OUTPUTS: begin
          // Previous write took effect at this edge
          @(negedge pld_avmm_clk);
          got_outputs = '0;
          got_outputs[REFCLK_SEL_W+1:0] = {refclk_sel, hclk_enable, fb_external};
          assert (got_outputs == stim_mem[base + 3])
            else report_failure($sformatf(
              "Mismatch {refclk_sel,hclk_enable,fb_external}: got 0x%04h expected 0x%04h",
              got_outputs, stim_mem[base + 3]));
        end
        default: begin
          report_failure($sformatf("Unknown op code 0x%h on stimulus line %0d", op, line_idx));
        end
      endcase
    end

    @(posedge pld_avmm_clk);
    write <= 1'b0;
    read  <= 1'b0;
    // Last read is sampled at this edge, its result is due one cycle later
    repeat (2) @(posedge pld_avmm_clk);
    assert (expected_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure($sformatf("%0d read results never came back", expected_q.size()));
    end
  end

endmodule

// ==== test/av_pll_reconfig_stim.txt ====
// Columns in hex: op address data expected
// op 0 idle data cycles, 1 write, 2 read, 3 pll_locked = data, 4 outputs {refclk_sel,hclk,fb}, f end
4 000 0000 0000
2 800 0000 0001
2 801 0000 0000
// CMU PLL feedback and hclk register
1 050 0003 0000
4 000 0000 0003
1 050 fffd 0000
4 000 0000 0001
2 050 0000 0001
1 050 0002 0000
2 050 0000 0002
4 000 0000 0002
// Refclk select, 11 and 15 are dropped
1 060 000a 0000
4 000 0000 002a
2 060 0000 000a
1 060 000b 0000
2 060 0000 000a
1 060 000f 0000
4 000 0000 002a
1 060 0003 0000
2 060 0000 0003
// Unmapped space, back to back
2 070 0000 0000
2 051 0000 0000
2 061 0000 0000
2 802 0000 0000
2 000 0000 0000
2 050 0000 0002
2 060 0000 0003
// Lock status and sticky flag
3 000 0001 0000
0 000 0004 0000
2 801 0000 0001
3 000 0000 0000
0 000 0004 0000
2 801 0000 0002
3 000 0001 0000
0 000 0004 0000
2 801 0000 0003
1 801 0002 0000
2 801 0000 0001
f 000 0000 0000

// ==== av_pll_reconfig.f ====
source/av_pll_reconfig_pkg.sv
source/avmm_port_if.sv
source/avmm_csr_dprio_split.sv
source/pll_soft_csr.sv
source/dprio_channel.sv
source/av_pll_reconfig.sv
test/tb_clock_gen.sv
test/tb_av_pll_reconfig.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_av_pll_reconfig
FILELIST  := av_pll_reconfig.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
